//--- rtl/amo_consts.svh
`ifndef AMO_CONSTS_SVH
`define AMO_CONSTS_SVH

//////////////////////////////
// bus widths
//////////////////////////////

// word address, 256 words
`define AMO_ADR_W 8

// data word
`define AMO_DAT_W 32

//////////////////////////////
// memory
//////////////////////////////

`define AMO_DEPTH 256

// read wait cycles counted by wait_timer
`define AMO_MEM_WAIT 2

`endif

//--- rtl/amo_pkg.sv
`default_nettype none

package amo_pkg;

  //////////////////////////////
  // atomic opcodes
  //////////////////////////////

  // write and swap both store wdt and return old word
  typedef enum logic [3:0] {
    OP_READ  = 4'd0,
    OP_WRITE = 4'd1,
    OP_SWAP  = 4'd2,
    OP_ADD   = 4'd3,
    OP_XOR   = 4'd4,
    OP_AND   = 4'd5,
    OP_OR    = 4'd6,
    OP_MIN   = 4'd7,
    OP_MAX   = 4'd8,
    OP_MINU  = 4'd9,
    OP_MAXU  = 4'd10
  } amo_op_e;

  //////////////////////////////
  // sequencer states
  //////////////////////////////

  typedef enum logic [2:0] {
    ST_IDLE  = 3'd0,
    ST_WAIT  = 3'd1,
    ST_WRITE = 3'd2,
    ST_RESP  = 3'd3
  } rmw_state_e;

endpackage

`default_nettype wire

//--- rtl/amo_alu.sv
`default_nettype none

`include "amo_consts.svh"

module amo_alu (
  input  amo_pkg::amo_op_e        op,
  input  logic [`AMO_DAT_W-1:0]   wdt,
  input  logic [`AMO_DAT_W-1:0]   rdt,
  output logic [`AMO_DAT_W-1:0]   new_wdt
);

  //////////////////////////////
  // shared comparator
  //////////////////////////////

  // unsigned compare for minu/maxu
  logic                  uns;
  // extension bits, sign or zero
  logic                  ext_w;
  logic                  ext_r;
  // one extra bit holds the sign of the difference
  logic [`AMO_DAT_W:0]   diff;
  // wdt below rdt
  logic                  lt;
  // plain sum for add, wraps
  logic [`AMO_DAT_W-1:0] sum;

  assign uns = (op == amo_pkg::OP_MINU) || (op == amo_pkg::OP_MAXU);

  // sign extension only for signed compare
  assign ext_w = ~uns & wdt[`AMO_DAT_W-1];
  assign ext_r = ~uns & rdt[`AMO_DAT_W-1];

  assign diff = {ext_w, wdt} - {ext_r, rdt};
  assign lt   = diff[`AMO_DAT_W];

  assign sum = wdt + rdt;

  //////////////////////////////
  // result select
  //////////////////////////////

  always_comb begin
    case (op)
      // read stores the old word back unchanged
      amo_pkg::OP_READ:  new_wdt = rdt;
      amo_pkg::OP_WRITE: new_wdt = wdt;
      amo_pkg::OP_SWAP:  new_wdt = wdt;
      amo_pkg::OP_ADD:   new_wdt = sum;
      // logic ops
      amo_pkg::OP_XOR:   new_wdt = wdt ^ rdt;
      amo_pkg::OP_AND:   new_wdt = wdt & rdt;
      amo_pkg::OP_OR:    new_wdt = wdt | rdt;
      // min picks the smaller one
      amo_pkg::OP_MIN:   new_wdt = lt ? wdt : rdt;
      amo_pkg::OP_MINU:  new_wdt = lt ? wdt : rdt;
      // max picks the larger one
      amo_pkg::OP_MAX:   new_wdt = lt ? rdt : wdt;
      amo_pkg::OP_MAXU:  new_wdt = lt ? rdt : wdt;
      // unknown opcode leaves memory as is
      default:           new_wdt = rdt;
    endcase
  end

endmodule

`default_nettype wire

//--- rtl/wait_timer.sv
`default_nettype none

`include "amo_consts.svh"

module wait_timer (
  input  logic clk,
  input  logic reset,
  input  logic start,
  output logic done
);

  // wide enough for the full wait count
  localparam int CNT_W = $clog2(`AMO_MEM_WAIT + 1);

  logic [CNT_W-1:0] cnt;
  // counting in progress
  logic             run;

  always_ff @(posedge clk) begin
    if (reset) begin
      cnt <= '0;
      run <= 1'b0;
    end else if (start) begin
      cnt <= CNT_W'(`AMO_MEM_WAIT);
      run <= 1'b1;
    end else if (run) begin
      if (cnt != '0) begin
        cnt <= cnt - 1'b1;
      end else begin
        // zero reached, stop after this cycle
        run <= 1'b0;
      end
    end
  end

  // one cycle at zero while running
  assign done = run && (cnt == '0);

endmodule

`default_nettype wire

//--- rtl/amo_mem.sv
`default_nettype none

`include "amo_consts.svh"

module amo_mem (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  rd,
  input  logic                  wr,
  input  logic [`AMO_ADR_W-1:0] adr,
  input  logic [`AMO_DAT_W-1:0] wdt,
  output logic [`AMO_DAT_W-1:0] rdt
);

  //////////////////////////////
  // storage
  //////////////////////////////

  logic [`AMO_DAT_W-1:0] mem [`AMO_DEPTH];

  // write on the edge with wr high
  always_ff @(posedge clk) begin
    if (wr) begin
      mem[adr] <= wdt;
    end
  end

  //////////////////////////////
  // read port
  //////////////////////////////

  // registered read word, held until the next rd
  // a write to the same word does not disturb it,
  // so the old word stays visible for the response
  always_ff @(posedge clk) begin
    if (reset) begin
      rdt <= '0;
    end else if (rd) begin
      rdt <= mem[adr];
    end
  end

endmodule

`default_nettype wire

//--- rtl/rmw_fsm.sv
`default_nettype none

module rmw_fsm (
  input  logic             clk,
  input  logic             reset,
  input  logic             vld,
  // latched opcode
  input  amo_pkg::amo_op_e op,
  input  logic             timer_done,
  output logic             rdy,
  output logic             req_take,
  output logic             timer_start,
  output logic             mem_rd,
  output logic             mem_wr,
  output logic             rsp_vld
);

  amo_pkg::rmw_state_e state;

  //////////////////////////////
  // handshake
  //////////////////////////////

  // only idle takes new work
  assign rdy      = (state == amo_pkg::ST_IDLE);
  assign req_take = vld & rdy;

  //////////////////////////////
  // state sequence
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      state       <= amo_pkg::ST_IDLE;
      mem_rd      <= 1'b0;
      timer_start <= 1'b0;
    end else begin
      // read strobe and timer kick, one cycle after acceptance
      mem_rd      <= req_take;
      timer_start <= req_take;
      case (state)
        amo_pkg::ST_IDLE: begin
          if (req_take) begin
            state <= amo_pkg::ST_WAIT;
          end
        end
        // memory read latency
        amo_pkg::ST_WAIT: begin
          if (timer_done) begin
            state <= amo_pkg::ST_WRITE;
          end
        end
        // single write-back cycle
        amo_pkg::ST_WRITE: begin
          state <= amo_pkg::ST_RESP;
        end
        // response pulse, then free again
        amo_pkg::ST_RESP: begin
          state <= amo_pkg::ST_IDLE;
        end
        default: begin
          state <= amo_pkg::ST_IDLE;
        end
      endcase
    end
  end

  //////////////////////////////
  // outputs from state
  //////////////////////////////

  // a read never writes back
  assign mem_wr  = (state == amo_pkg::ST_WRITE) && (op != amo_pkg::OP_READ);

  assign rsp_vld = (state == amo_pkg::ST_RESP);

endmodule

`default_nettype wire

//--- rtl/amo_rmw_top.sv
`default_nettype none

`include "amo_consts.svh"

module amo_rmw_top (
  input  logic                  clk,
  input  logic                  reset,
  // request
  input  logic                  vld,
  input  amo_pkg::amo_op_e      op,
  input  logic [`AMO_ADR_W-1:0] adr,
  input  logic [`AMO_DAT_W-1:0] wdt,
  output logic                  rdy,
  // response
  output logic                  rsp_vld,
  output logic [`AMO_DAT_W-1:0] rsp_rdt
);

  // internal nets
  logic                  req_take;
  logic                  timer_start;
  logic                  timer_done;
  logic                  mem_rd;
  logic                  mem_wr;
  logic [`AMO_DAT_W-1:0] mem_rdt;
  logic [`AMO_DAT_W-1:0] new_wdt;

  // request latches
  amo_pkg::amo_op_e      op_r;
  logic [`AMO_ADR_W-1:0] adr_r;
  logic [`AMO_DAT_W-1:0] wdt_r;

  //////////////////////////////
  // request capture
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (req_take) begin
      op_r  <= op;
      adr_r <= adr;
      wdt_r <= wdt;
    end
  end

  //////////////////////////////
  // datapath and control
  //////////////////////////////

  rmw_fsm u_fsm (
    .clk         (clk),
    .reset       (reset),
    .vld         (vld),
    .op          (op_r),
    .timer_done  (timer_done),
    .rdy         (rdy),
    .req_take    (req_take),
    .timer_start (timer_start),
    .mem_rd      (mem_rd),
    .mem_wr      (mem_wr),
    .rsp_vld     (rsp_vld)
  );

  wait_timer u_timer (
    .clk   (clk),
    .reset (reset),
    .start (timer_start),
    .done  (timer_done)
  );

  amo_mem u_mem (
    .clk   (clk),
    .reset (reset),
    .rd    (mem_rd),
    .wr    (mem_wr),
    .adr   (adr_r),
    .wdt   (new_wdt),
    .rdt   (mem_rdt)
  );

  amo_alu u_alu (
    .op      (op_r),
    .wdt     (wdt_r),
    .rdt     (mem_rdt),
    .new_wdt (new_wdt)
  );

  // old word goes back to the requester
  assign rsp_rdt = mem_rdt;

endmodule

`default_nettype wire

//--- tb/amo_rmw_assert.sv
`default_nettype none

`include "amo_consts.svh"

module amo_rmw_assert (
  input logic             clk,
  input logic             reset,
  input logic             vld,
  input logic             rdy,
  input logic             rsp_vld,
  input logic             mem_wr,
  input amo_pkg::amo_op_e op
);

  //////////////////////////////
  // handshake and response
  //////////////////////////////

  // response is a one cycle pulse
  a_rsp_pulse: assert property (@(posedge clk) disable iff (reset)
    rsp_vld |=> !rsp_vld)
    else $error("rsp_vld high for more than one cycle");

  // rises at edge T + wait + 3, first sampled one edge later
  a_rsp_latency: assert property (@(posedge clk) disable iff (reset)
    (vld && rdy) |=> (!rsp_vld) [*(`AMO_MEM_WAIT + 3)] ##1 rsp_vld)
    else $error("rsp_vld not at fixed latency after acceptance");

  // busy from acceptance through the response cycle
  a_busy: assert property (@(posedge clk) disable iff (reset)
    (vld && rdy) |=> (!rdy) [*(`AMO_MEM_WAIT + 4)])
    else $error("rdy high while an operation is in flight");

  // an accepted read never writes back during its whole sequence
  a_read_no_wr: assert property (@(posedge clk) disable iff (reset)
    (vld && rdy && (op == amo_pkg::OP_READ)) |=> (!mem_wr) [*(`AMO_MEM_WAIT + 4)])
    else $error("mem_wr high for a read");

endmodule

bind amo_rmw_top amo_rmw_assert u_assert (
  .clk     (clk),
  .reset   (reset),
  .vld     (vld),
  .rdy     (rdy),
  .rsp_vld (rsp_vld),
  .mem_wr  (mem_wr),
  .op      (op)
);

`default_nettype wire

//--- tb/amo_rmw_tb.sv
`default_nettype none

`include "amo_consts.svh"

module amo_rmw_tb;

  localparam int TIMEOUT = 50;
  localparam int N_STEP  = 17;
  localparam int N_RAND  = 200;

  // one directed step, exp is the old word returned
  typedef struct packed {
    amo_pkg::amo_op_e      op;
    logic [`AMO_ADR_W-1:0] adr;
    logic [`AMO_DAT_W-1:0] wdt;
    logic [`AMO_DAT_W-1:0] exp;
  } step_t;

  localparam step_t STEPS [N_STEP] = '{
    // write then read twice
    '{amo_pkg::OP_WRITE, 8'd1, 32'h1234_5678, 32'hA501_FE01},
    '{amo_pkg::OP_READ,  8'd1, 32'h0000_0000, 32'h1234_5678},
    '{amo_pkg::OP_READ,  8'd1, 32'h0000_0000, 32'h1234_5678},
    // swap and plain store
    '{amo_pkg::OP_SWAP,  8'd1, 32'hCAFE_F00D, 32'h1234_5678},
    '{amo_pkg::OP_WRITE, 8'd1, 32'h0000_0005, 32'hCAFE_F00D},
    // add wraps to 3
    '{amo_pkg::OP_ADD,   8'd1, 32'hFFFF_FFFE, 32'h0000_0005},
    '{amo_pkg::OP_XOR,   8'd1, 32'h0000_00FF, 32'h0000_0003},
    '{amo_pkg::OP_OR,    8'd1, 32'hF000_0000, 32'h0000_00FC},
    '{amo_pkg::OP_AND,   8'd1, 32'h0F0F_00F0, 32'hF000_00FC},
    '{amo_pkg::OP_READ,  8'd1, 32'h0000_0000, 32'h0000_00F0},
    // signed vs unsigned picks on a negative word
    '{amo_pkg::OP_WRITE, 8'd2, 32'hFFFF_FFF0, 32'hA502_FD02},
    '{amo_pkg::OP_MIN,   8'd2, 32'h0000_0010, 32'hFFFF_FFF0},
    '{amo_pkg::OP_MINU,  8'd2, 32'h0000_0010, 32'hFFFF_FFF0},
    '{amo_pkg::OP_MAX,   8'd2, 32'hFFFF_FFF0, 32'h0000_0010},
    '{amo_pkg::OP_MAXU,  8'd2, 32'hFFFF_FFF0, 32'h0000_0010},
    '{amo_pkg::OP_MAX,   8'd2, 32'h0000_0010, 32'hFFFF_FFF0},
    '{amo_pkg::OP_READ,  8'd2, 32'h0000_0000, 32'h0000_0010}
  };

  logic                  clk;
  logic                  reset;
  logic                  vld;
  amo_pkg::amo_op_e      op;
  logic [`AMO_ADR_W-1:0] adr;
  logic [`AMO_DAT_W-1:0] wdt;
  logic                  rdy;
  logic                  rsp_vld;
  logic [`AMO_DAT_W-1:0] rsp_rdt;

  // reference memory, 8 colliding words
  logic [`AMO_DAT_W-1:0] model [8];
  logic [31:0]           seed;
  logic [`AMO_DAT_W-1:0] old;
  amo_pkg::amo_op_e      r_op;
  logic [`AMO_ADR_W-1:0] r_adr;

  amo_rmw_top DUT (
    .clk     (clk),
    .reset   (reset),
    .vld     (vld),
    .op      (op),
    .adr     (adr),
    .wdt     (wdt),
    .rdy     (rdy),
    .rsp_vld (rsp_vld),
    .rsp_rdt (rsp_rdt)
  );

  always #4 clk = ~clk;

  //////////////////////////////
  // reference rules
  //////////////////////////////

  function automatic logic [31:0] init_word(input logic [7:0] a);
    return {8'hA5, a, ~a, a};
  endfunction

  // new word from request data and old word
  function automatic logic [31:0] expect_word(input amo_pkg::amo_op_e o,
      input logic [31:0] d, input logic [31:0] w);
    case (o)
      amo_pkg::OP_WRITE, amo_pkg::OP_SWAP: return d;
      amo_pkg::OP_ADD:  return d + w;
      amo_pkg::OP_XOR:  return d ^ w;
      amo_pkg::OP_AND:  return d & w;
      amo_pkg::OP_OR:   return d | w;
      amo_pkg::OP_MIN:  return ($signed(d) < $signed(w)) ? d : w;
      amo_pkg::OP_MAX:  return ($signed(d) > $signed(w)) ? d : w;
      amo_pkg::OP_MINU: return (d < w) ? d : w;
      amo_pkg::OP_MAXU: return (d > w) ? d : w;
      default:          return w;
    endcase
  endfunction

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  //////////////////////////////
  // bus tasks
  //////////////////////////////

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("RESULT: FAIL");
    $fatal(1);
  endtask

  task automatic check_word(input string name, input logic [31:0] got,
      input logic [31:0] exp);
    assert (got === exp)
      else fail_run($sformatf("[ERROR] %s got %h expected %h", name, got, exp));
  endtask

  // returns at the negedge before the accepting edge
  task automatic wait_ready();
    int n;
    n = 0;
    @(negedge clk);
    while (!rdy) begin
      n++;
      assert (n <= TIMEOUT) else fail_run("timeout while waiting for rdy");
      @(negedge clk);
    end
  endtask

  // rdy must stay low until the response
  task automatic wait_response(output logic [31:0] rdt);
    int n;
    n = 0;
    @(negedge clk);
    while (!rsp_vld) begin
      assert (!rdy) else fail_run("rdy went high before the response");
      n++;
      assert (n <= TIMEOUT) else fail_run("timeout while waiting for rsp_vld");
      @(negedge clk);
    end
    rdt = rsp_rdt;
  endtask

  task automatic drive_req(input amo_pkg::amo_op_e o, input logic [7:0] a,
      input logic [31:0] d);
    vld = 1'b1;
    op  = o;
    adr = a;
    wdt = d;
  endtask

  task automatic run_op(input amo_pkg::amo_op_e o, input logic [7:0] a,
      input logic [31:0] d, output logic [31:0] rdt);
    @(posedge clk);
    #1;
    drive_req(o, a, d);
    wait_ready();
    @(posedge clk);
    #1;
    vld = 1'b0;
    wait_response(rdt);
  endtask

  // old word against model, then model update
  task automatic apply_model(input amo_pkg::amo_op_e o, input logic [7:0] a,
      input logic [31:0] d, input logic [31:0] rdt);
    check_word("rsp_rdt", rdt, model[a[2:0]]);
    model[a[2:0]] = expect_word(o, d, model[a[2:0]]);
  endtask

  //////////////////////////////
  // test sequence
  //////////////////////////////

  initial begin
    clk   = 1'b0;
    reset = 1'b1;
    vld   = 1'b0;
    op    = amo_pkg::OP_READ;
    adr   = '0;
    wdt   = '0;
    seed  = 32'h1090_c7f7;
    repeat (5) @(posedge clk);
    #1;
    reset = 1'b0;
    @(negedge clk);
    assert (rdy) else fail_run("rdy low after reset");

    // known contents for every address in use
    for (int a = 0; a < 8; a++) begin
      run_op(amo_pkg::OP_WRITE, 8'(a), init_word(8'(a)), old);
      model[a] = init_word(8'(a));
    end

    for (int i = 0; i < N_STEP; i++) begin
      run_op(STEPS[i].op, STEPS[i].adr, STEPS[i].wdt, old);
      check_word("rsp_rdt", old, STEPS[i].exp);
      apply_model(STEPS[i].op, STEPS[i].adr, STEPS[i].wdt, old);
    end

    // second request held on vld through a busy period
    @(posedge clk);
    #1;
    drive_req(amo_pkg::OP_ADD, 8'd3, 32'h0000_0001);
    wait_ready();
    @(posedge clk);
    #1;
    drive_req(amo_pkg::OP_XOR, 8'd4, 32'hFFFF_0000);
    wait_response(old);
    apply_model(amo_pkg::OP_ADD, 8'd3, 32'h0000_0001, old);
    wait_ready();
    @(posedge clk);
    #1;
    vld = 1'b0;
    wait_response(old);
    apply_model(amo_pkg::OP_XOR, 8'd4, 32'hFFFF_0000, old);
    repeat (`AMO_MEM_WAIT + 6) begin
      @(negedge clk);
      assert (!rsp_vld) else fail_run("held request answered more than once");
    end

    // mixed operations on colliding words
    for (int i = 0; i < N_RAND; i++) begin
      seed  = lcg_next(seed);
      r_op  = amo_pkg::amo_op_e'(4'(seed[27:24] % 4'd11));
      r_adr = `AMO_ADR_W'(seed[18:16]);
      seed  = lcg_next(seed);
      run_op(r_op, r_adr, seed, old);
      apply_model(r_op, r_adr, seed, old);
    end

    $display("RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

//--- all.f
+incdir+rtl
rtl/amo_pkg.sv
rtl/amo_alu.sv
rtl/wait_timer.sv
rtl/amo_mem.sv
rtl/rmw_fsm.sv
rtl/amo_rmw_top.sv
tb/amo_rmw_assert.sv
tb/amo_rmw_tb.sv

//--- Bender.yml
package:
  name: amo_rmw

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/amo_pkg.sv
      - rtl/amo_alu.sv
      - rtl/wait_timer.sv
      - rtl/amo_mem.sv
      - rtl/rmw_fsm.sv
      - rtl/amo_rmw_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - tb/amo_rmw_assert.sv
      - tb/amo_rmw_tb.sv
